//--- Makefile
TOP = tb_video_zoom

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o vsim

run: build
	./obj_dir/vsim | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- hdl/line_buffer.sv
// line buffer: two-page pixel memory, synchronous write and registered read
`timescale 1ns/1ns
`include "zoom_config.svh"

module line_buffer (
  input  logic                     clk,
  input  zoom_ctrl_pkg::ram_wr_t   wr,
  input  zoom_ctrl_pkg::buf_addr_t rd_addr,
  output zoom_video_pkg::pixel_t   rd_data
);

  import zoom_video_pkg::*;

  localparam int depth = 2 ** `ZOOM_ADDR_WIDTH;

  pixel_t mem [depth];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/line_phase_fsm.sv
// line phase FSM: tracks the four line phases and routes averaged pixels into the buffers
`timescale 1ns/1ns
`include "zoom_config.svh"

module line_phase_fsm #(
  parameter int line_length = `ZOOM_LINE_LENGTH
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  vs_in,
  input  zoom_video_pkg::hpix_t hpix,
  output zoom_ctrl_pkg::ram_wr_t wr0,
  output zoom_ctrl_pkg::ram_wr_t wr1,
  output logic                  pair_ready,
  output logic                  ready_page,
  output logic                  frame_clr
);

  import zoom_ctrl_pkg::*;

  localparam int col_w = `ZOOM_ADDR_WIDTH - 1;
  localparam logic [col_w-1:0] half_cnt = col_w'(line_length / 2);

  logic              vs_d0;
  logic              vs_d1;
  line_phase_e       phase;
  line_phase_e       next_phase;
  logic [col_w-1:0]  wr_col;
  logic              cur_page;
  logic              is_line_b;
  logic              wr_hit;
  buf_addr_t         wr_addr;

  // vs falling edge restarts the frame
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vs_d0 <= 1'b0;
      vs_d1 <= 1'b0;
    end else begin
      vs_d0 <= vs_in;
      vs_d1 <= vs_d0;
    end
  end

  assign frame_clr = vs_d1 && !vs_d0;

  assign cur_page  = (phase == line_a_page1) || (phase == line_b_page1);
  assign is_line_b = (phase == line_b_page0) || (phase == line_b_page1);

  always_comb begin
    case (phase)
      line_a_page0: next_phase = line_b_page0;
      line_b_page0: next_phase = line_a_page1;
      line_a_page1: next_phase = line_b_page1;
      default:      next_phase = line_a_page0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      phase      <= line_a_page0;
      wr_col     <= '0;
      pair_ready <= 1'b0;
      ready_page <= 1'b0;
    end else if (frame_clr) begin
      phase      <= line_a_page0;
      wr_col     <= '0;
      pair_ready <= 1'b0;
    end else begin
      pair_ready <= 1'b0;
      if (wr_col == half_cnt) begin  // half-line complete
        wr_col <= '0;
        phase  <= next_phase;
        if (is_line_b) begin
          pair_ready <= 1'b1;
          ready_page <= cur_page;  // page just filled in both buffers
        end
      end else if (hpix.valid) begin
        wr_col <= wr_col + 1'b1;
      end
    end
  end

  assign wr_hit  = hpix.valid && !frame_clr;
  assign wr_addr = {cur_page, wr_col};

  always_comb begin
    wr0.en   = wr_hit && !is_line_b;  // line a of the pair
    wr0.addr = wr_addr;
    wr0.data = hpix.pix;
    wr1.en   = wr_hit && is_line_b;
    wr1.addr = wr_addr;
    wr1.data = hpix.pix;
  end

endmodule

//--- hdl/pair_averager.sv
// horizontal stage: pairs up incoming pixels and emits their per-channel average
`timescale 1ns/1ns

module pair_averager (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   frame_clr,
  input  logic                   de_in,
  input  zoom_video_pkg::pixel_t video_data_in,
  output zoom_video_pkg::hpix_t  hpix
);

  import zoom_video_pkg::*;

  logic   pair_phase;  // high once the first pixel of a pair is held
  pixel_t first_pix;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pair_phase <= 1'b0;
      hpix.valid <= 1'b0;
    end else begin
      hpix.valid <= 1'b0;  // single cycle pulse
      if (frame_clr || !de_in) begin
        pair_phase <= 1'b0;  // a new line always starts on a first pixel
      end else if (!pair_phase) begin
        first_pix  <= video_data_in;
        pair_phase <= 1'b1;
      end else begin
        pair_phase <= 1'b0;
        hpix.valid <= 1'b1;
        hpix.pix   <= half_sum(first_pix, video_data_in);
      end
    end
  end

endmodule

//--- hdl/readout_timer.sv
// readout timer: issues one burst of column reads from the ready page after each line pair
`timescale 1ns/1ns
`include "zoom_config.svh"

module readout_timer #(
  parameter int line_length = `ZOOM_LINE_LENGTH
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   frame_clr,
  input  logic                   pair_ready,
  input  logic                   ready_page,
  output zoom_ctrl_pkg::rd_req_t rd_req
);

  localparam int col_w = `ZOOM_ADDR_WIDTH - 1;
  localparam logic [col_w-1:0] last_col = col_w'(line_length / 2 - 1);

  logic             busy;
  logic             rd_page;  // latched at burst start
  logic [col_w-1:0] rd_col;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      rd_page <= 1'b0;
      rd_col  <= '0;
    end else if (frame_clr) begin
      busy   <= 1'b0;
      rd_col <= '0;
    end else if (pair_ready) begin
      busy    <= 1'b1;
      rd_page <= ready_page;
      rd_col  <= '0;
    end else if (busy) begin
      if (rd_col == last_col) begin
        busy   <= 1'b0;
        rd_col <= '0;
      end else begin
        rd_col <= rd_col + 1'b1;
      end
    end
  end

  always_comb begin
    rd_req.valid = busy;
    rd_req.addr  = {rd_page, rd_col};
  end

endmodule

//--- hdl/vertical_averager.sv
// vertical stage: averages the two buffer outputs and drives the scaled video out
`timescale 1ns/1ns

module vertical_averager (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   frame_clr,
  input  logic                   rd_valid,
  input  zoom_video_pkg::pixel_t rd_data0,
  input  zoom_video_pkg::pixel_t rd_data1,
  output logic                   de_out,
  output zoom_video_pkg::pixel_t video_data_out
);

  import zoom_video_pkg::*;

  logic rd_valid_d;  // lines up with the buffer read latency

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_valid_d     <= 1'b0;
      de_out         <= 1'b0;
      video_data_out <= '0;
    end else if (frame_clr) begin
      rd_valid_d     <= 1'b0;
      de_out         <= 1'b0;
      video_data_out <= '0;
    end else begin
      rd_valid_d     <= rd_valid;
      de_out         <= rd_valid_d;
      // zero outside the burst
      video_data_out <= rd_valid_d ? half_sum(rd_data0, rd_data1) : '0;
    end
  end

endmodule

//--- hdl/video_zoom.sv
// 2:1 bilinear video downscaler top level
`timescale 1ns/1ns
`include "zoom_config.svh"

module video_zoom #(
  parameter int line_length = `ZOOM_LINE_LENGTH
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   vs_in,
  input  logic                   de_in,
  input  zoom_video_pkg::pixel_t video_data_in,
  output logic                   de_out,
  output zoom_video_pkg::pixel_t video_data_out
);

  import zoom_video_pkg::*;
  import zoom_ctrl_pkg::*;

  hpix_t   hpix;
  ram_wr_t wr0;
  ram_wr_t wr1;
  rd_req_t rd_req;
  pixel_t  rd_data0;
  pixel_t  rd_data1;
  logic    frame_clr;
  logic    pair_ready;
  logic    ready_page;

  pair_averager u_pair_averager (
    .clk           (clk),
    .rstn          (rstn),
    .frame_clr     (frame_clr),
    .de_in         (de_in),
    .video_data_in (video_data_in),
    .hpix          (hpix)
  );

  line_phase_fsm #(.line_length(line_length)) u_line_phase_fsm (
    .clk        (clk),
    .rstn       (rstn),
    .vs_in      (vs_in),
    .hpix       (hpix),
    .wr0        (wr0),
    .wr1        (wr1),
    .pair_ready (pair_ready),
    .ready_page (ready_page),
    .frame_clr  (frame_clr)
  );

  readout_timer #(.line_length(line_length)) u_readout_timer (
    .clk        (clk),
    .rstn       (rstn),
    .frame_clr  (frame_clr),
    .pair_ready (pair_ready),
    .ready_page (ready_page),
    .rd_req     (rd_req)
  );

  // even lines
  line_buffer buf0 (
    .clk     (clk),
    .wr      (wr0),
    .rd_addr (rd_req.addr),
    .rd_data (rd_data0)
  );

  // odd lines
  line_buffer buf1 (
    .clk     (clk),
    .wr      (wr1),
    .rd_addr (rd_req.addr),
    .rd_data (rd_data1)
  );

  vertical_averager u_vertical_averager (
    .clk            (clk),
    .rstn           (rstn),
    .frame_clr      (frame_clr),
    .rd_valid       (rd_req.valid),
    .rd_data0       (rd_data0),
    .rd_data1       (rd_data1),
    .de_out         (de_out),
    .video_data_out (video_data_out)
  );

endmodule

//--- hdl/zoom_config.svh
// video zoom configuration: line length, channel and pixel widths, buffer addressing
`ifndef ZOOM_CONFIG_SVH
`define ZOOM_CONFIG_SVH

// input pixels per active line, must be even
`define ZOOM_LINE_LENGTH 1920

`define ZOOM_CHAN_WIDTH 10   // one colour channel
`define ZOOM_PIXEL_WIDTH 32  // packed pixel, three channels plus two spare bits

// 1 page bit on top of 10 column bits
`define ZOOM_ADDR_WIDTH 11

`endif

//--- hdl/zoom_ctrl_pkg.sv
// control types for the downscaler: line phases, buffer addresses, read and write requests
`include "zoom_config.svh"

package zoom_ctrl_pkg;

  // even lines go to buffer 0, odd lines to buffer 1, page flips every pair
  typedef enum logic [1:0] {
    line_a_page0 = 2'd0,
    line_b_page0 = 2'd1,
    line_a_page1 = 2'd2,
    line_b_page1 = 2'd3
  } line_phase_e;

  typedef logic [`ZOOM_ADDR_WIDTH-1:0] buf_addr_t;  // {page, column}

  typedef struct packed {
    logic                  en;
    buf_addr_t             addr;
    zoom_video_pkg::pixel_t data;
  } ram_wr_t;

  typedef struct packed {
    logic      valid;
    buf_addr_t addr;
  } rd_req_t;

endpackage

//--- hdl/zoom_video_pkg.sv
// video data types for the 2:1 downscaler and the per-channel averaging rule
`include "zoom_config.svh"

package zoom_video_pkg;

  typedef logic [`ZOOM_CHAN_WIDTH-1:0] chan_t;
  typedef logic [`ZOOM_PIXEL_WIDTH-1:0] pixel_t;

  // horizontally averaged pixel on its way to the line buffers
  typedef struct packed {
    logic   valid;
    pixel_t pix;
  } hpix_t;

  // half of a plus half of b per channel, each half rounded down
  function automatic pixel_t half_sum(pixel_t a, pixel_t b);
    pixel_t s;
    s = '0;  // bits 1:0 stay zero
    s[31:22] = chan_t'(a[31:22] >> 1) + chan_t'(b[31:22] >> 1);
    s[21:12] = chan_t'(a[21:12] >> 1) + chan_t'(b[21:12] >> 1);
    s[11:2] = chan_t'(a[11:2] >> 1) + chan_t'(b[11:2] >> 1);
    return s;
  endfunction

endpackage

//--- sim.f
+incdir+hdl
hdl/zoom_video_pkg.sv
hdl/zoom_ctrl_pkg.sv
hdl/pair_averager.sv
hdl/line_phase_fsm.sv
hdl/readout_timer.sv
hdl/line_buffer.sv
hdl/vertical_averager.sv
hdl/video_zoom.sv
tests/video_zoom_asserts.sv
tests/tb_video_zoom.sv

//--- tests/tb_video_zoom.sv
// testbench for the 2:1 downscaler: directed line pair tests against a reference model
`timescale 1ns/1ns

module tb_video_zoom;

  import zoom_video_pkg::*;

  localparam int line_len = 16;
  localparam int half = line_len / 2;
  // rough cycle budget: reset, idle, one pair, both pages, restart, long blanking
  localparam int test_cycles = 20 + 40 + 120 + 200 + 200 + 260;
  localparam int watchdog_ns = test_cycles * 2 * 40;

  logic   clk;
  logic   rstn;
  logic   vs_in;
  logic   de_in;
  pixel_t video_data_in;
  logic   de_out;
  pixel_t video_data_out;

  int     seed = 32'h25da5a94;
  pixel_t lines [4][16];
  pixel_t exp_q [$];
  pixel_t exp_v;
  string  test_name;
  int     err_count = 0;
  int     errs_at_start = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  int     run_len = 0;  // length of the current de_out burst

  video_zoom #(.line_length(line_len)) dut (
    .clk            (clk),
    .rstn           (rstn),
    .vs_in          (vs_in),
    .de_in          (de_in),
    .video_data_in  (video_data_in),
    .de_out         (de_out),
    .video_data_out (video_data_out)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // per channel half of a plus half of b, halves rounded down
  function automatic logic [9:0] chan_avg(logic [9:0] a, logic [9:0] b);
    logic [9:0] ha;
    logic [9:0] hb;
    ha = {1'b0, a[9:1]};
    hb = {1'b0, b[9:1]};
    return ha + hb;
  endfunction

  function automatic pixel_t model_avg(pixel_t a, pixel_t b);
    return {chan_avg(a[31:22], b[31:22]), chan_avg(a[21:12], b[21:12]),
            chan_avg(a[11:2], b[11:2]), 2'b00};
  endfunction

  // expected outputs of one line pair, line a over line b
  task automatic push_pair(input int a, input int b);
    pixel_t ha;
    pixel_t hb;
    for (int c = 0; c < half; c++) begin
      ha = model_avg(lines[a][2*c], lines[a][2*c+1]);
      hb = model_avg(lines[b][2*c], lines[b][2*c+1]);
      exp_q.push_back(model_avg(ha, hb));
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < line_len; j++) begin
        lines[i][j] = $random(seed);
      end
    end
  endtask

  task automatic frame_start();
    @(negedge clk);
    vs_in = 1'b1;
    repeat (3) @(negedge clk);
    vs_in = 1'b0;  // falling edge restarts the frame
    repeat (4) @(negedge clk);
  endtask

  // npix pixels of line idx, then gap cycles of blanking
  task automatic send_line(input int idx, input int npix, input int gap);
    for (int i = 0; i < npix; i++) begin
      @(negedge clk);
      de_in = 1'b1;
      video_data_in = lines[idx][i];
    end
    @(negedge clk);
    de_in = 1'b0;
    video_data_in = '0;
    repeat (gap - 1) @(negedge clk);
  endtask

  function automatic int short_gap();
    return 2 + ({$random(seed)} % 4);
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || run_len != 0) && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected outputs never appeared", test_name, exp_q.size());
      err_count++;
      exp_q.delete();
    end
    repeat (6) @(negedge clk);  // catch stray outputs
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errs_at_start = err_count;
  endtask

  task automatic finish_test();
    if (err_count == errs_at_start) begin
      pass_count++;
      $display("%s: passed", test_name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", test_name, err_count - errs_at_start);
    end
  endtask

  task automatic test_idle();
    start_test("idle");
    repeat (30) @(negedge clk);  // monitor flags any output
    finish_test();
  endtask

  task automatic test_one_pair();
    logic [9:0] v;
    start_test("one_pair");
    for (int i = 0; i < line_len; i++) begin
      v = 10'(i * 64 + 1);  // odd values, dropped low bits would carry
      lines[0][i] = {v, ~v, v ^ 10'h155, 2'b11};
      lines[1][i] = {10'h3ff - v, v + 10'd2, 10'(i * 3 + 1), 2'b01};
    end
    frame_start();
    push_pair(0, 1);
    send_line(0, line_len, short_gap());
    send_line(1, line_len, short_gap());
    wait_drain();
    finish_test();
  endtask

  task automatic test_both_pages();
    start_test("both_pages");
    fill_random();
    frame_start();
    push_pair(0, 1);
    push_pair(2, 3);  // second pair lands in page 1
    for (int i = 0; i < 4; i++) begin
      send_line(i, line_len, short_gap());
    end
    wait_drain();
    finish_test();
  endtask

  task automatic test_frame_restart();
    start_test("frame_restart");
    fill_random();
    frame_start();
    send_line(0, line_len, short_gap());
    send_line(1, 9, short_gap());  // line b cut short
    frame_start();
    push_pair(2, 3);
    send_line(2, line_len, short_gap());
    send_line(3, line_len, short_gap());
    wait_drain();
    finish_test();
  endtask

  task automatic test_long_blank();
    start_test("long_blank");
    fill_random();
    frame_start();
    push_pair(0, 1);
    push_pair(2, 3);
    for (int i = 0; i < 4; i++) begin
      send_line(i, line_len, 20 + ({$random(seed)} % 12));
    end
    wait_drain();
    finish_test();
  endtask

  // output monitor, sampled away from the rising edge
  always @(negedge clk) begin
    if (rstn) begin
      if (de_out) begin
        run_len = run_len + 1;
        if (exp_q.size() == 0) begin
          $display("%s: unexpected output %h", test_name, video_data_out);
          err_count++;
        end else begin
          exp_v = exp_q.pop_front();
          if (video_data_out !== exp_v) begin
            $display("Fail %s expected %h actual %h", test_name, exp_v, video_data_out);
            err_count++;
          end
        end
      end else begin
        if (video_data_out !== '0) begin
          $display("%s: video_data_out not zero while de_out is low", test_name);
          err_count++;
        end
        if (run_len != 0 && run_len != half) begin
          $display("%s: burst of %0d outputs where %0d were expected",
                   test_name, run_len, half);
          err_count++;
        end
        run_len = 0;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: simulation ran past its time budget");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rstn = 1'b0;
    vs_in = 1'b0;
    de_in = 1'b0;
    video_data_in = '0;
    test_name = "reset";
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    test_idle();
    test_one_pair();
    test_both_pages();
    test_frame_restart();
    test_long_blank();
    if (dut.u_asserts.assert_fails != 0) begin
      $display("bound assertions failed %0d times", dut.u_asserts.assert_fails);
      fail_count++;
    end
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tests/video_zoom_asserts.sv
// bound checker for the downscaler: write exclusivity, read column range, output latency
`timescale 1ns/1ns
`include "zoom_config.svh"

module video_zoom_asserts #(
  parameter int line_length = `ZOOM_LINE_LENGTH
) (
  input logic                   clk,
  input logic                   rstn,
  input zoom_ctrl_pkg::ram_wr_t wr0,
  input zoom_ctrl_pkg::ram_wr_t wr1,
  input zoom_ctrl_pkg::rd_req_t rd_req,
  input logic                   de_out
);

  localparam int col_w = `ZOOM_ADDR_WIDTH - 1;
  localparam logic [col_w-1:0] half_cols = col_w'(line_length / 2);

  int assert_fails = 0;  // read back by the testbench

  // one buffer written per cycle
  wr_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    !(wr0.en && wr1.en))
    else begin
      $error("wr0 and wr1 enabled in the same cycle");
      assert_fails = assert_fails + 1;
    end

  rd_col_range: assert property (@(posedge clk) disable iff (!rstn)
    rd_req.valid |-> (rd_req.addr[col_w-1:0] < half_cols))
    else begin
      $error("read column outside the half line");
      assert_fails = assert_fails + 1;
    end

  // buffer read plus output register
  de_out_latency: assert property (@(posedge clk) disable iff (!rstn)
    rd_req.valid |-> ##2 de_out)
    else begin
      $error("de_out did not follow a read request by 2 cycles");
      assert_fails = assert_fails + 1;
    end

endmodule

bind video_zoom video_zoom_asserts #(.line_length(line_length)) u_asserts (
  .clk    (clk),
  .rstn   (rstn),
  .wr0    (wr0),
  .wr1    (wr1),
  .rd_req (rd_req),
  .de_out (de_out)
);
